//--- list.f
+incdir+rtl
rtl/conv_geom_pkg.sv
rtl/conv_mem_pkg.sv
rtl/conv_tile_sched.sv
rtl/conv_tile_addr.sv
rtl/conv_out_index.sv
rtl/conv_layer_seq.sv
sim/tb_conv_layer_seq.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_conv_layer_seq
FILELIST  := list.f
OBJDIR    := obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- sim/tb_conv_layer_seq.sv
`timescale 1ns/10ps
`include "conv_macros.svh"

module tb_conv_layer_seq;

    localparam int NUM_ROWS = 4;
    localparam int NUM_TILES = `CONV_ICH_B * 2 * `CONV_OX_B * (`CONV_OY / 2) * `CONV_OCH_B;
    localparam int WAIT_LIMIT = 64;

    logic clk;
    logic areset;
    logic i_run;
    logic i_core_n_ready;
    logic i_core_ot_valid;
    conv_mem_pkg::otfmap_t i_core_ot_data;

    logic o_core_run;
    logic o_core_scaling;
    conv_mem_pkg::infmap_addr_t o_infmap_addr;
    conv_mem_pkg::infmap_word_t o_infmap_word;
    conv_mem_pkg::weight_addr_t o_weight_addr;
    conv_mem_pkg::bias_addr_t o_bias_addr;
    logic o_run;
    logic o_idle;
    logic o_en_err;
    logic o_n_ready;
    logic o_done;
    logic o_ot_valid;
    conv_mem_pkg::otfmap_t o_ot_data;
    conv_geom_pkg::ox_b_t o_ot_ox_b;
    conv_geom_pkg::ox_t_t o_ot_ox_t;
    conv_geom_pkg::oy_t o_ot_oy;
    conv_geom_pkg::och_b_t o_ot_och_b;

    // ==============================
    // Test table
    // ==============================
    // Columns are delay bits, second start mid-layer and expected error flag
    int row_bits[NUM_ROWS] = '{0, 2, 3, 0};
    bit row_mid_run[NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};
    bit row_err[NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};

    logic [15:0] lfsr;
    int row_errors;
    int total_errors;
    int rows_failed;
    int beat_count;

    conv_layer_seq uut (
        .clk             (clk),
        .areset          (areset),
        .i_run           (i_run),
        .i_core_n_ready  (i_core_n_ready),
        .i_core_ot_valid (i_core_ot_valid),
        .i_core_ot_data  (i_core_ot_data),
        .o_core_run      (o_core_run),
        .o_core_scaling  (o_core_scaling),
        .o_infmap_addr   (o_infmap_addr),
        .o_infmap_word   (o_infmap_word),
        .o_weight_addr   (o_weight_addr),
        .o_bias_addr     (o_bias_addr),
        .o_run           (o_run),
        .o_idle          (o_idle),
        .o_en_err        (o_en_err),
        .o_n_ready       (o_n_ready),
        .o_done          (o_done),
        .o_ot_valid      (o_ot_valid),
        .o_ot_data       (o_ot_data),
        .o_ot_ox_b       (o_ot_ox_b),
        .o_ot_ox_t       (o_ot_ox_t),
        .o_ot_oy         (o_ot_oy),
        .o_ot_och_b      (o_ot_och_b)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            row_errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("Test failures found");
        $finish;
    endtask

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 16'hB400;
        end
        return shifted;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic clear_strobes();
        i_run = 1'b0;
        i_core_n_ready = 1'b0;
        i_core_ot_valid = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        areset = 1'b1;
        clear_strobes();
        i_core_ot_data = '0;
        repeat (5) @(negedge clk);
        areset = 1'b0;
    endtask

    task automatic check_idle_state();
        check_eq("o_core_run", 32'(o_core_run), 0);
        check_eq("o_core_scaling", 32'(o_core_scaling), 0);
        check_eq("o_run", 32'(o_run), 0);
        check_eq("o_idle", 32'(o_idle), 1);
        check_eq("o_en_err", 32'(o_en_err), 0);
        check_eq("o_n_ready", 32'(o_n_ready), 0);
        check_eq("o_done", 32'(o_done), 0);
        check_eq("o_infmap_addr", 32'(o_infmap_addr), 0);
        check_eq("o_infmap_word", 32'(o_infmap_word), 0);
        check_eq("o_weight_addr", 32'(o_weight_addr), 0);
        check_eq("o_bias_addr", 32'(o_bias_addr), 0);
        check_eq("o_ot_ox_b", 32'(o_ot_ox_b), 0);
        check_eq("o_ot_ox_t", 32'(o_ot_ox_t), 0);
        check_eq("o_ot_oy", 32'(o_ot_oy), 0);
        check_eq("o_ot_och_b", 32'(o_ot_och_b), 0);
    endtask

    // ==============================
    // Reference model
    // ==============================
    // Tile order ich_b, oy0, ox_b, oy1, och_b from the inside out
    task automatic check_tile(input int k);
        int ich_b;
        int ox_b;
        int oy;
        int och_b;
        int fidx;
        ich_b = k % `CONV_ICH_B;
        oy = ((k / (`CONV_ICH_B * 2 * `CONV_OX_B)) % (`CONV_OY / 2)) * 2 +
             (k / `CONV_ICH_B) % 2;
        ox_b = (k / (`CONV_ICH_B * 2)) % `CONV_OX_B;
        och_b = k / (`CONV_ICH_B * 2 * `CONV_OX_B * (`CONV_OY / 2));
        fidx = ich_b * `CONV_ICH_T * `CONV_IY * `CONV_IX + oy * `CONV_IX + ox_b * `CONV_OX_T;
        check_eq("o_core_scaling", 32'(o_core_scaling), 32'(ich_b == `CONV_ICH_B - 1));
        check_eq("o_infmap_addr", 32'(o_infmap_addr), fidx / `CONV_FMAP_WORD);
        check_eq("o_infmap_word", 32'(o_infmap_word), fidx % `CONV_FMAP_WORD);
        check_eq("o_weight_addr", 32'(o_weight_addr),
                 och_b * `CONV_OCH_T * `CONV_ICH * `CONV_KY + ich_b * `CONV_ICH_T * `CONV_KY);
        check_eq("o_bias_addr", 32'(o_bias_addr), och_b * `CONV_OCH_T);
    endtask

    // Beat order ox_t, oy0, ox_b, oy1, och_b from the inside out
    task automatic check_beat(input int b, input logic [31:0] data);
        int oy;
        oy = ((b / (`CONV_OX_T * 2 * `CONV_OX_B)) % (`CONV_OY / 2)) * 2 + (b / `CONV_OX_T) % 2;
        check_eq("o_ot_valid", 32'(o_ot_valid), 1);
        check_eq("o_ot_data", 32'(o_ot_data), data);
        check_eq("o_ot_ox_t", 32'(o_ot_ox_t), b % `CONV_OX_T);
        check_eq("o_ot_ox_b", 32'(o_ot_ox_b), (b / (`CONV_OX_T * 2)) % `CONV_OX_B);
        check_eq("o_ot_oy", 32'(o_ot_oy), oy);
        check_eq("o_ot_och_b", 32'(o_ot_och_b), b / (`CONV_OX_T * 2 * `CONV_OX_B * (`CONV_OY / 2)));
    endtask

    task automatic wait_core_run(input int k);
        int cycles;
        cycles = 0;
        @(negedge clk);
        clear_strobes();
        while (!o_core_run) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run($sformatf("no core run pulse arrived for tile %0d", k));
            end
            @(negedge clk);
            clear_strobes();
        end
    endtask

    // ==============================
    // Core model and layer run
    // ==============================
    task automatic run_layer(input int bits, input bit mid_run);
        int delay;
        logic [31:0] rnd;
        @(negedge clk);
        i_run = 1'b1;
        for (int k = 0; k < NUM_TILES; k++) begin
            wait_core_run(k);
            check_tile(k);
            // Scaling tiles deliver their output beats first
            if (k % `CONV_ICH_B == `CONV_ICH_B - 1) begin
                for (int j = 0; j < `CONV_OX_T; j++) begin
                    @(negedge clk);
                    i_core_ot_valid = 1'b1;
                    draw_bits(32, rnd);
                    i_core_ot_data = rnd;
                    #1;
                    check_beat(beat_count, rnd);
                    check_eq("o_core_run", 32'(o_core_run), 0);
                    beat_count++;
                end
            end
            draw_bits(bits, rnd);
            delay = 3 + int'(rnd);
            for (int i = 1; i < delay; i++) begin
                @(negedge clk);
                clear_strobes();
                if (mid_run && k == NUM_TILES / 2 && i == 1) begin
                    i_run = 1'b1;
                end
                check_eq("o_core_run", 32'(o_core_run), 0);
            end
            @(negedge clk);
            clear_strobes();
            i_core_n_ready = 1'b1;
            check_eq("o_core_run", 32'(o_core_run), 0);
        end
    endtask

    // Status pulses after the last core ready
    task automatic check_layer_end(input bit exp_err);
        @(negedge clk);
        clear_strobes();
        check_eq("o_n_ready", 32'(o_n_ready), 1);
        check_eq("o_done", 32'(o_done), 0);
        check_eq("o_run", 32'(o_run), 1);
        check_eq("o_core_run", 32'(o_core_run), 0);
        @(negedge clk);
        check_eq("o_n_ready", 32'(o_n_ready), 0);
        check_eq("o_done", 32'(o_done), 1);
        check_eq("o_run", 32'(o_run), 1);
        check_eq("o_idle", 32'(o_idle), 0);
        @(negedge clk);
        check_eq("o_done", 32'(o_done), 0);
        check_eq("o_run", 32'(o_run), 0);
        check_eq("o_idle", 32'(o_idle), 1);
        repeat (4) begin
            @(negedge clk);
            check_eq("o_core_run", 32'(o_core_run), 0);
        end
        check_eq("o_en_err", 32'(o_en_err), 32'(exp_err));
        // Beat index wraps to zero after the last beat of the layer
        check_eq("o_ot_ox_t", 32'(o_ot_ox_t), 0);
        check_eq("o_ot_ox_b", 32'(o_ot_ox_b), 0);
        check_eq("o_ot_oy", 32'(o_ot_oy), 0);
        check_eq("o_ot_och_b", 32'(o_ot_och_b), 0);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        areset = 1'b1;
        i_run = 1'b0;
        i_core_n_ready = 1'b0;
        i_core_ot_valid = 1'b0;
        i_core_ot_data = '0;
        lfsr = 16'd45;
        total_errors = 0;
        rows_failed = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            row_errors = 0;
            beat_count = 0;
            apply_reset();
            check_idle_state();
            run_layer(row_bits[r], row_mid_run[r]);
            check_layer_end(row_err[r]);
            if (row_errors == 0) begin
                $display("Row %0d (delay bits %0d, second start %0d): passed",
                         r, row_bits[r], row_mid_run[r]);
            end else begin
                $display("Row %0d (delay bits %0d, second start %0d): failed, %0d errors",
                         r, row_bits[r], row_mid_run[r], row_errors);
                rows_failed++;
            end
            total_errors += row_errors;
        end
        $display("Rows run %0d, passed %0d, failed %0d, check errors %0d",
                 NUM_ROWS, NUM_ROWS - rows_failed, rows_failed, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- rtl/conv_layer_seq.sv
`timescale 1ns/10ps

module conv_layer_seq (
    input  logic                        clk,
    input  logic                        areset,
    input  logic                        i_run,
    input  logic                        i_core_n_ready,
    input  logic                        i_core_ot_valid,
    input  conv_mem_pkg::otfmap_t       i_core_ot_data,
    output logic                        o_core_run,
    output logic                        o_core_scaling,
    output conv_mem_pkg::infmap_addr_t  o_infmap_addr,
    output conv_mem_pkg::infmap_word_t  o_infmap_word,
    output conv_mem_pkg::weight_addr_t  o_weight_addr,
    output conv_mem_pkg::bias_addr_t    o_bias_addr,
    output logic                        o_run,
    output logic                        o_idle,
    output logic                        o_en_err,
    output logic                        o_n_ready,
    output logic                        o_done,
    output logic                        o_ot_valid,
    output conv_mem_pkg::otfmap_t       o_ot_data,
    output conv_geom_pkg::ox_b_t        o_ot_ox_b,
    output conv_geom_pkg::ox_t_t        o_ot_ox_t,
    output conv_geom_pkg::oy_t          o_ot_oy,
    output conv_geom_pkg::och_b_t       o_ot_och_b
);

    // Block counters of the tile being issued
    conv_geom_pkg::ich_b_t w_ich_b;
    conv_geom_pkg::ox_b_t  w_ox_b;
    conv_geom_pkg::oy_t    w_oy;
    conv_geom_pkg::och_b_t w_och_b;

    // ==============================
    // Tile issue side
    // ==============================
    conv_tile_sched u_tile_sched (
        .clk            (clk),
        .areset         (areset),
        .i_run          (i_run),
        .i_core_n_ready (i_core_n_ready),
        .o_core_run     (o_core_run),
        .o_core_scaling (o_core_scaling),
        .o_run          (o_run),
        .o_idle         (o_idle),
        .o_en_err       (o_en_err),
        .o_n_ready      (o_n_ready),
        .o_done         (o_done),
        .o_ich_b        (w_ich_b),
        .o_ox_b         (w_ox_b),
        .o_oy           (w_oy),
        .o_och_b        (w_och_b)
    );

    conv_tile_addr u_tile_addr (
        .clk           (clk),
        .areset        (areset),
        .i_ich_b       (w_ich_b),
        .i_ox_b        (w_ox_b),
        .i_oy          (w_oy),
        .i_och_b       (w_och_b),
        .o_infmap_addr (o_infmap_addr),
        .o_infmap_word (o_infmap_word),
        .o_weight_addr (o_weight_addr),
        .o_bias_addr   (o_bias_addr)
    );

    // ==============================
    // Output beat side
    // ==============================
    conv_out_index u_out_index (
        .clk        (clk),
        .areset     (areset),
        .i_ot_valid (i_core_ot_valid),
        .o_ox_b     (o_ot_ox_b),
        .o_ox_t     (o_ot_ox_t),
        .o_oy       (o_ot_oy),
        .o_och_b    (o_ot_och_b)
    );

    // Beats leave in the cycle they arrive
    assign o_ot_valid = i_core_ot_valid;
    assign o_ot_data  = i_core_ot_data;

endmodule

//--- rtl/conv_out_index.sv
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_out_index (
    input  logic                   clk,
    input  logic                   areset,
    input  logic                   i_ot_valid,
    output conv_geom_pkg::ox_b_t   o_ox_b,
    output conv_geom_pkg::ox_t_t   o_ox_t,
    output conv_geom_pkg::oy_t     o_oy,
    output conv_geom_pkg::och_b_t  o_och_b
);

    localparam conv_geom_pkg::ox_t_t OX_T_PEN = conv_geom_pkg::ox_t_t'(`CONV_OX_T - 2);
    localparam conv_geom_pkg::ox_t_t OX_T_LAST = conv_geom_pkg::ox_t_t'(`CONV_OX_T - 1);
    localparam conv_geom_pkg::ox_b_t OX_B_LAST = conv_geom_pkg::ox_b_t'(`CONV_OX_B - 1);
    localparam conv_geom_pkg::oy1_t OY1_LAST = conv_geom_pkg::oy1_t'(`CONV_OY / 2 - 1);
    localparam conv_geom_pkg::oy_t OY_LAST = conv_geom_pkg::oy_t'(`CONV_OY - 1);
    localparam conv_geom_pkg::och_b_t OCH_B_LAST = conv_geom_pkg::och_b_t'(`CONV_OCH_B - 1);

    conv_geom_pkg::ox_t_t  r_ox_t;
    logic                  r_oy0;
    conv_geom_pkg::ox_b_t  r_ox_b;
    conv_geom_pkg::oy1_t   r_oy1;
    conv_geom_pkg::och_b_t r_och_b;

    logic r_ox_t_last;
    logic r_oy0_last;
    logic r_ox_b_last;
    logic r_oy1_last;
    logic r_och_b_last;

    logic w_pen;

    // ==============================
    // Beat index loop nest
    // ==============================
    assign w_pen = (r_ox_t == OX_T_PEN);

    always_ff @(posedge clk) begin
        if (areset) begin
            r_ox_t       <= '0;
            r_oy0        <= 1'b0;
            r_ox_b       <= '0;
            r_oy1        <= '0;
            r_och_b      <= '0;
            r_ox_t_last  <= 1'b0;
            r_oy0_last   <= 1'b0;
            r_ox_b_last  <= 1'b0;
            r_oy1_last   <= 1'b0;
            r_och_b_last <= 1'b0;
        end else if (i_ot_valid) begin
            r_ox_t      <= r_ox_t_last ? '0 : r_ox_t + conv_geom_pkg::ox_t_t'(1);
            r_ox_t_last <= w_pen;
            if (r_ox_t_last) begin
                r_oy0 <= ~r_oy0;
            end
            r_oy0_last <= w_pen && r_oy0;
            if (r_oy0_last) begin
                r_ox_b <= r_ox_b_last ? '0 : r_ox_b + conv_geom_pkg::ox_b_t'(1);
            end
            r_ox_b_last <= w_pen && r_oy0 && (r_ox_b == OX_B_LAST);
            if (r_ox_b_last) begin
                r_oy1 <= r_oy1_last ? '0 : r_oy1 + conv_geom_pkg::oy1_t'(1);
            end
            r_oy1_last <= w_pen && r_oy0 && (r_ox_b == OX_B_LAST) && (r_oy1 == OY1_LAST);
            // Wraps to zero after the last beat of the layer
            if (r_oy1_last) begin
                r_och_b <= r_och_b_last ? '0 : r_och_b + conv_geom_pkg::och_b_t'(1);
            end
            r_och_b_last <= w_pen && r_oy0 && (r_ox_b == OX_B_LAST) && (r_oy1 == OY1_LAST) &&
                            (r_och_b == OCH_B_LAST);
        end
    end

    // Index of the beat now on the bus
    assign o_ox_t  = r_ox_t;
    assign o_ox_b  = r_ox_b;
    assign o_oy    = {r_oy1, r_oy0};
    assign o_och_b = r_och_b;

    a_index_range: assert property (@(posedge clk) disable iff (areset)
        (o_ox_t <= OX_T_LAST) && (o_oy <= OY_LAST))
        else $error("output index out of range");

endmodule

//--- rtl/conv_tile_addr.sv
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_tile_addr (
    input  logic                        clk,
    input  logic                        areset,
    input  conv_geom_pkg::ich_b_t       i_ich_b,
    input  conv_geom_pkg::ox_b_t        i_ox_b,
    input  conv_geom_pkg::oy_t          i_oy,
    input  conv_geom_pkg::och_b_t       i_och_b,
    output conv_mem_pkg::infmap_addr_t  o_infmap_addr,
    output conv_mem_pkg::infmap_word_t  o_infmap_word,
    output conv_mem_pkg::weight_addr_t  o_weight_addr,
    output conv_mem_pkg::bias_addr_t    o_bias_addr
);

    // Feature element index, word address above the element bits
    localparam int FIDX_BW = `CONV_INFMAP_ADDR_BW + `CONV_INFMAP_WORD_BW;

    localparam int F_ICHB_STEP = `CONV_ICH_T * `CONV_IY * `CONV_IX;
    localparam int F_OY_STEP = `CONV_IX;
    localparam int F_OXB_STEP = `CONV_OX_T;
    localparam int W_OCHB_STEP = `CONV_OCH_T * `CONV_ICH * `CONV_KY;
    localparam int W_ICHB_STEP = `CONV_ICH_T * `CONV_KY;
    localparam int B_OCHB_STEP = `CONV_OCH_T;

    logic [FIDX_BW-1:0]         r_f_ichb;
    logic [FIDX_BW-1:0]         r_f_oy;
    logic [FIDX_BW-1:0]         r_f_oxb;
    conv_mem_pkg::weight_addr_t r_w_ochb;
    conv_mem_pkg::weight_addr_t r_w_ichb;
    conv_mem_pkg::bias_addr_t   r_b_ochb;

    logic [FIDX_BW-1:0]         r_f_idx;
    conv_mem_pkg::weight_addr_t r_weight;
    conv_mem_pkg::bias_addr_t   r_bias;

    // ==============================
    // Stage 1, partial products
    // ==============================
    always_ff @(posedge clk) begin
        if (areset) begin
            r_f_ichb <= '0;
            r_f_oy   <= '0;
            r_f_oxb  <= '0;
            r_w_ochb <= '0;
            r_w_ichb <= '0;
            r_b_ochb <= '0;
        end else begin
            r_f_ichb <= FIDX_BW'(i_ich_b * F_ICHB_STEP);
            r_f_oy   <= FIDX_BW'(i_oy * F_OY_STEP);
            r_f_oxb  <= FIDX_BW'(i_ox_b * F_OXB_STEP);
            r_w_ochb <= conv_mem_pkg::weight_addr_t'(i_och_b * W_OCHB_STEP);
            r_w_ichb <= conv_mem_pkg::weight_addr_t'(i_ich_b * W_ICHB_STEP);
            r_b_ochb <= conv_mem_pkg::bias_addr_t'(i_och_b * B_OCHB_STEP);
        end
    end

    // ==============================
    // Stage 2, sums
    // ==============================
    always_ff @(posedge clk) begin
        if (areset) begin
            r_f_idx  <= '0;
            r_weight <= '0;
            r_bias   <= '0;
        end else begin
            r_f_idx  <= r_f_ichb + r_f_oy + r_f_oxb;
            r_weight <= r_w_ochb + r_w_ichb;
            r_bias   <= r_b_ochb;
        end
    end

    // Four elements per word, so a plain bit split
    assign o_infmap_addr = r_f_idx[FIDX_BW-1:`CONV_INFMAP_WORD_BW];
    assign o_infmap_word = r_f_idx[`CONV_INFMAP_WORD_BW-1:0];
    assign o_weight_addr = r_weight;
    assign o_bias_addr   = r_bias;

endmodule

//--- rtl/conv_tile_sched.sv
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_tile_sched (
    input  logic                   clk,
    input  logic                   areset,
    input  logic                   i_run,
    input  logic                   i_core_n_ready,
    output logic                   o_core_run,
    output logic                   o_core_scaling,
    output logic                   o_run,
    output logic                   o_idle,
    output logic                   o_en_err,
    output logic                   o_n_ready,
    output logic                   o_done,
    output conv_geom_pkg::ich_b_t  o_ich_b,
    output conv_geom_pkg::ox_b_t   o_ox_b,
    output conv_geom_pkg::oy_t     o_oy,
    output conv_geom_pkg::och_b_t  o_och_b
);

    localparam conv_geom_pkg::ich_b_t ICH_B_PEN = conv_geom_pkg::ich_b_t'(`CONV_ICH_B - 2);
    localparam conv_geom_pkg::ox_b_t OX_B_LAST = conv_geom_pkg::ox_b_t'(`CONV_OX_B - 1);
    localparam conv_geom_pkg::oy1_t OY1_LAST = conv_geom_pkg::oy1_t'(`CONV_OY / 2 - 1);
    localparam conv_geom_pkg::och_b_t OCH_B_LAST = conv_geom_pkg::och_b_t'(`CONV_OCH_B - 1);

    conv_geom_pkg::ich_b_t r_ich_b;
    logic                  r_oy0;
    conv_geom_pkg::ox_b_t  r_ox_b;
    conv_geom_pkg::oy1_t   r_oy1;
    conv_geom_pkg::och_b_t r_och_b;

    // Counter sits on its last value, registered
    logic r_ich_b_last;
    logic r_oy0_last;
    logic r_ox_b_last;
    logic r_oy1_last;
    logic r_och_b_last;
    logic r_all_done;

    logic r_core_run;
    logic r_core_scaling;
    logic r_run;
    logic r_en_err;
    logic r_n_ready;
    logic r_done;

    logic w_pen;
    logic w_next_run;

    // ==============================
    // Block loop nest
    // ==============================
    // ich_b is one step from its last value
    assign w_pen = (r_ich_b == ICH_B_PEN);

    always_ff @(posedge clk) begin
        if (areset) begin
            r_ich_b      <= '0;
            r_oy0        <= 1'b0;
            r_ox_b       <= '0;
            r_oy1        <= '0;
            r_och_b      <= '0;
            r_ich_b_last <= 1'b0;
            r_oy0_last   <= 1'b0;
            r_ox_b_last  <= 1'b0;
            r_oy1_last   <= 1'b0;
            r_och_b_last <= 1'b0;
        end else if (r_core_run) begin
            r_ich_b      <= r_ich_b_last ? '0 : r_ich_b + conv_geom_pkg::ich_b_t'(1);
            r_ich_b_last <= w_pen;
            if (r_ich_b_last) begin
                r_oy0 <= ~r_oy0;
            end
            r_oy0_last <= w_pen && r_oy0;
            if (r_oy0_last) begin
                r_ox_b <= r_ox_b_last ? '0 : r_ox_b + conv_geom_pkg::ox_b_t'(1);
            end
            r_ox_b_last <= w_pen && r_oy0 && (r_ox_b == OX_B_LAST);
            if (r_ox_b_last) begin
                r_oy1 <= r_oy1_last ? '0 : r_oy1 + conv_geom_pkg::oy1_t'(1);
            end
            r_oy1_last <= w_pen && r_oy0 && (r_ox_b == OX_B_LAST) && (r_oy1 == OY1_LAST);
            if (r_oy1_last) begin
                r_och_b <= r_och_b_last ? '0 : r_och_b + conv_geom_pkg::och_b_t'(1);
            end
            r_och_b_last <= w_pen && r_oy0 && (r_ox_b == OX_B_LAST) && (r_oy1 == OY1_LAST) &&
                            (r_och_b == OCH_B_LAST);
        end
    end

    // Last tile issued, no further run pulse
    always_ff @(posedge clk) begin
        if (areset || r_n_ready) begin
            r_all_done <= 1'b0;
        end else if (r_core_run && r_och_b_last) begin
            r_all_done <= 1'b1;
        end
    end

    // ==============================
    // Core run strobes
    // ==============================
    // A start while busy only raises the error flag
    assign w_next_run = (i_run && !r_run) || (i_core_n_ready && !r_all_done);

    always_ff @(posedge clk) begin
        if (areset) begin
            r_core_run     <= 1'b0;
            r_core_scaling <= 1'b0;
        end else begin
            r_core_run     <= w_next_run;
            r_core_scaling <= w_next_run && r_ich_b_last;
        end
    end

    // ==============================
    // Layer status
    // ==============================
    always_ff @(posedge clk) begin
        if (areset) begin
            r_run     <= 1'b0;
            r_en_err  <= 1'b0;
            r_n_ready <= 1'b0;
            r_done    <= 1'b0;
        end else begin
            if (i_run) begin
                r_run <= 1'b1;
            end else if (r_done) begin
                r_run <= 1'b0;
            end
            if (r_run && i_run && !r_done) begin
                r_en_err <= 1'b1;
            end
            r_n_ready <= i_core_n_ready && r_all_done;
            r_done    <= r_n_ready;
        end
    end

    assign o_core_run     = r_core_run;
    assign o_core_scaling = r_core_scaling;
    assign o_run          = r_run;
    assign o_idle         = ~r_run;
    assign o_en_err       = r_en_err;
    assign o_n_ready      = r_n_ready;
    assign o_done         = r_done;
    assign o_ich_b        = r_ich_b;
    assign o_ox_b         = r_ox_b;
    assign o_oy           = {r_oy1, r_oy0};
    assign o_och_b        = r_och_b;

    // Run pulses are single cycle
    a_run_pulse: assert property (@(posedge clk) disable iff (areset)
        r_core_run |=> !r_core_run)
        else $error("core run held for two cycles");

    // Start addresses need three cycles to settle behind the counters
    a_ready_gap: assert property (@(posedge clk) disable iff (areset)
        r_core_run |-> !i_core_n_ready [*3])
        else $error("core ready within 3 cycles of run");

endmodule

//--- rtl/conv_mem_pkg.sv
`include "conv_macros.svh"

package conv_mem_pkg;

    // ==============================
    // Memory start addresses
    // ==============================
    typedef logic [`CONV_INFMAP_ADDR_BW-1:0] infmap_addr_t;
    typedef logic [`CONV_INFMAP_WORD_BW-1:0] infmap_word_t;
    typedef logic [`CONV_WEIGHT_ADDR_BW-1:0] weight_addr_t;
    typedef logic [`CONV_BIAS_ADDR_BW-1:0] bias_addr_t;

    // One output beat, OCH_T requantized channels side by side
    typedef logic [`CONV_OTFMAP_BW-1:0] otfmap_t;

endpackage

//--- rtl/conv_geom_pkg.sv
`include "conv_macros.svh"

package conv_geom_pkg;

    // ==============================
    // Tile loop nest counters
    // ==============================

    // Input-channel block, innermost tile loop
    typedef logic [`CONV_ICH_B_BW-1:0] ich_b_t;

    // Column block and column inside a block
    typedef logic [`CONV_OX_B_BW-1:0] ox_b_t;
    typedef logic [`CONV_OX_T_BW-1:0] ox_t_t;

    // Full output row, built as {oy1, oy0}
    typedef logic [`CONV_OY_BW-1:0] oy_t;

    // Row pair, upper bits of the row
    typedef logic [`CONV_OY_BW-2:0] oy1_t;

    // Output-channel block, outermost loop
    typedef logic [`CONV_OCH_B_BW-1:0] och_b_t;

endpackage

//--- rtl/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// ==============================
// Layer dimensions
// ==============================
`define CONV_ICH 6
`define CONV_OCH 16
`define CONV_KX 5
`define CONV_KY 5
`define CONV_OX 10
`define CONV_OY 10

// Block counts and per-block sizes
`define CONV_ICH_B 2
`define CONV_OCH_B 4
`define CONV_OX_B 2
`define CONV_ICH_T (`CONV_ICH / `CONV_ICH_B)
`define CONV_OCH_T (`CONV_OCH / `CONV_OCH_B)
`define CONV_OX_T (`CONV_OX / `CONV_OX_B)

// Input map, valid convolution
`define CONV_IX (`CONV_OX + `CONV_KX - 1)
`define CONV_IY (`CONV_OY + `CONV_KY - 1)

// Feature memory packing
`define CONV_FMAP_BW 8
`define CONV_FMAP_WORD 4

// ==============================
// Derived widths
// ==============================
`define CONV_ICH_B_BW $clog2(`CONV_ICH_B)
`define CONV_OX_B_BW $clog2(`CONV_OX_B)
`define CONV_OX_T_BW $clog2(`CONV_OX_T)
`define CONV_OY_BW $clog2(`CONV_OY)
`define CONV_OCH_B_BW $clog2(`CONV_OCH_B)
`define CONV_INFMAP_WORD_BW $clog2(`CONV_FMAP_WORD)
`define CONV_INFMAP_ADDR_BW $clog2(`CONV_ICH * `CONV_IY * `CONV_IX / `CONV_FMAP_WORD)
`define CONV_WEIGHT_ADDR_BW $clog2(`CONV_OCH * `CONV_ICH * `CONV_KY)
`define CONV_BIAS_ADDR_BW $clog2(`CONV_OCH)
`define CONV_OTFMAP_BW (`CONV_OCH_T * `CONV_FMAP_BW)

`endif
